// File: common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 2 ** REG_AW;

    localparam logic [REG_AW-1:0] REG_ZERO = '0;

    // sll $0,$0,0
    localparam logic [XLEN-1:0] INST_NOP = '0;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL funct field, inst[5:0]
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

endpackage

`default_nettype wire

// File: common/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI     // passes operand b through
    } alu_op_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        alu_op_t           alu_op;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] dest;
        logic              wreg;
        logic              load;
        logic              store;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   result;   // alu result or data address
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] dest;
        logic              wreg;
        logic              load;
        logic              store;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   wdata;
        logic [REG_AW-1:0] dest;
        logic              wreg;
    } mem_wb_t;

    // one enable per stage register
    typedef struct packed {
        logic pc;
        logic if_id;
        logic id_ex;
        logic ex_mem;
        logic mem_wb;
    } stage_en_t;

endpackage

`default_nettype wire

// File: decode/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic [mips_isa_pkg::XLEN-1:0]   pc_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   inst_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   rs_data_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   rt_data_i,
    output logic [mips_isa_pkg::REG_AW-1:0] rs_addr_o,
    output logic [mips_isa_pkg::REG_AW-1:0] rt_addr_o,
    input  logic [mips_isa_pkg::REG_AW-1:0] ex_wd_i,
    input  logic                            ex_wreg_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   ex_wdata_i,
    input  logic [mips_isa_pkg::REG_AW-1:0] mem_wd_i,
    input  logic                            mem_wreg_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   mem_wdata_i,
    output mips_pipe_pkg::id_ex_t           id_ex_o,
    output logic                            branch_o,
    output logic [mips_isa_pkg::XLEN-1:0]   branch_target_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [5:0]        op;
    logic [5:0]        funct;
    logic [REG_AW-1:0] rd;
    logic [15:0]       imm;
    logic [XLEN-1:0]   imm_sext;
    logic [XLEN-1:0]   rs_val;
    logic [XLEN-1:0]   rt_val;

    assign op        = inst_i[31:26];
    assign rs_addr_o = inst_i[25:21];
    assign rt_addr_o = inst_i[20:16];
    assign rd        = inst_i[15:11];
    assign funct     = inst_i[5:0];
    assign imm       = inst_i[15:0];
    assign imm_sext  = {{(XLEN-16){imm[15]}}, imm};

    // younger producer wins, so execute before memory
    assign rs_val = (ex_wreg_i && ex_wd_i == rs_addr_o)   ? ex_wdata_i  :
                    (mem_wreg_i && mem_wd_i == rs_addr_o) ? mem_wdata_i : rs_data_i;
    assign rt_val = (ex_wreg_i && ex_wd_i == rt_addr_o)   ? ex_wdata_i  :
                    (mem_wreg_i && mem_wd_i == rt_addr_o) ? mem_wdata_i : rt_data_i;

    // offset is relative to the delay slot
    assign branch_target_o = pc_i + XLEN'(4) + {imm_sext[XLEN-3:0], 2'b00};

    always_comb begin
        id_ex_o            = '0;
        id_ex_o.pc         = pc_i;
        id_ex_o.op_a       = rs_val;
        id_ex_o.store_data = rt_val;
        branch_o           = 1'b0;

        case (op)
            OP_SPECIAL: begin
                id_ex_o.valid = 1'b1;
                id_ex_o.wreg  = 1'b1;
                id_ex_o.dest  = rd;
                id_ex_o.op_b  = rt_val;
                case (funct)
                    FN_ADDU: id_ex_o.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_o.alu_op = ALU_SUB;
                    FN_AND:  id_ex_o.alu_op = ALU_AND;
                    FN_OR:   id_ex_o.alu_op = ALU_OR;
                    FN_XOR:  id_ex_o.alu_op = ALU_XOR;
                    FN_SLT:  id_ex_o.alu_op = ALU_SLT;
                    default: begin      // unsupported, becomes a no-op
                        id_ex_o.valid = 1'b0;
                        id_ex_o.wreg  = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                id_ex_o.valid  = 1'b1;
                id_ex_o.wreg   = 1'b1;
                id_ex_o.dest   = rt_addr_o;
                id_ex_o.op_b   = imm_sext;
                id_ex_o.load   = (op == OP_LW);
                id_ex_o.alu_op = ALU_ADD;
                if (op == OP_ORI) begin
                    id_ex_o.op_b   = {{(XLEN-16){1'b0}}, imm};
                    id_ex_o.alu_op = ALU_OR;
                end else if (op == OP_LUI) begin
                    id_ex_o.op_b   = {imm, 16'h0000};
                    id_ex_o.alu_op = ALU_LUI;
                end
            end
            OP_SW: begin
                id_ex_o.valid  = 1'b1;
                id_ex_o.store  = 1'b1;
                id_ex_o.op_b   = imm_sext;
                id_ex_o.alu_op = ALU_ADD;
            end
            OP_BEQ, OP_BNE: begin
                id_ex_o.valid = 1'b1;
                branch_o      = (rs_val == rt_val) ^ (op == OP_BNE);
            end
            default: ;
        endcase

        if (id_ex_o.dest == REG_ZERO) id_ex_o.wreg = 1'b0;
    end

endmodule

`default_nettype wire

// File: decode/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            we_i,
    input  logic [mips_isa_pkg::REG_AW-1:0] waddr_i,
    input  logic [mips_isa_pkg::XLEN-1:0]   wdata_i,
    input  logic [mips_isa_pkg::REG_AW-1:0] raddr1_i,
    input  logic [mips_isa_pkg::REG_AW-1:0] raddr2_i,
    output logic [mips_isa_pkg::XLEN-1:0]   rdata1_o,
    output logic [mips_isa_pkg::XLEN-1:0]   rdata2_o
);

    import mips_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != REG_ZERO) regs[waddr_i] <= wdata_i;
    end

    // write-back value is visible to decode in the same cycle
    assign rdata1_o = (raddr1_i == REG_ZERO)            ? '0      :
                      (we_i && waddr_i == raddr1_i)     ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == REG_ZERO)            ? '0      :
                      (we_i && waddr_i == raddr2_i)     ? wdata_i : regs[raddr2_i];

    // decode drops writes to $0 long before they get here
    no_zero_write: assert property (@(posedge clk) disable iff (rst)
        we_i |-> waddr_i != REG_ZERO);

endmodule

`default_nettype wire

// File: mips_core.f
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
src/pipe_reg.sv
src/fetch_unit.sv
decode/regfile.sv
decode/decoder.sv
src/alu_stage.sv
src/mem_access.sv
src/mips_core.sv
verif/tb_mips_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mips_core \
    -f mips_core.f \
    && ./obj_dir/Vtb_mips_core 2>&1 | tee sim.log \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/alu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_stage (
    input  mips_pipe_pkg::id_ex_t           id_ex_i,
    output mips_pipe_pkg::ex_mem_t          ex_mem_o,
    output logic [mips_isa_pkg::REG_AW-1:0] ex_wd_o,
    output logic                            ex_wreg_o,
    output logic [mips_isa_pkg::XLEN-1:0]   ex_wdata_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;

    assign a = id_ex_i.op_a;
    assign b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = a + b;    // also lw/sw address
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_LUI: result = b;
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_mem_o.valid      = id_ex_i.valid;
        ex_mem_o.pc         = id_ex_i.pc;
        ex_mem_o.result     = result;
        ex_mem_o.store_data = id_ex_i.store_data;
        ex_mem_o.dest       = id_ex_i.dest;
        ex_mem_o.wreg       = id_ex_i.wreg;
        ex_mem_o.load       = id_ex_i.load;
        ex_mem_o.store      = id_ex_i.store;
    end

    // load data is not here yet, the core stalls instead
    assign ex_wd_o    = id_ex_i.dest;
    assign ex_wreg_o  = id_ex_i.valid && id_ex_i.wreg && !id_ex_i.load;
    assign ex_wdata_o = result;

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          en_pc_i,
    input  logic                          en_if_id_i,
    input  logic                          branch_i,
    input  logic [mips_isa_pkg::XLEN-1:0] branch_target_i,
    output logic [mips_isa_pkg::XLEN-1:0] inst_addr_o,
    input  logic [mips_isa_pkg::XLEN-1:0] inst_rdata_i,
    output logic [mips_isa_pkg::XLEN-1:0] id_pc_o,
    output logic [mips_isa_pkg::XLEN-1:0] id_inst_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0] pc;

    assign inst_addr_o = pc;    // imem answers in the same cycle

    // branch seen in decode while the delay slot is being fetched here
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (en_pc_i) begin
            pc <= branch_i ? branch_target_i : pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc_o   <= '0;
            id_inst_o <= INST_NOP;
        end else if (en_if_id_i) begin
            id_pc_o   <= pc;
            id_inst_o <= inst_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_access.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access (
    input  mips_pipe_pkg::ex_mem_t          ex_mem_i,
    output logic                            data_req_o,
    output logic                            data_wr_o,
    output logic [mips_isa_pkg::XLEN-1:0]   data_addr_o,
    output logic [mips_isa_pkg::XLEN-1:0]   data_wdata_o,
    input  logic [mips_isa_pkg::XLEN-1:0]   data_rdata_i,
    input  logic                            data_data_ok_i,
    output logic                            mem_stall_o,
    output mips_pipe_pkg::mem_wb_t          mem_wb_o,
    output logic [mips_isa_pkg::REG_AW-1:0] mem_wd_o,
    output logic                            mem_wreg_o,
    output logic [mips_isa_pkg::XLEN-1:0]   mem_wdata_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0] wdata;
    logic            wreg;

    // request is a level, held while ex_mem is frozen
    assign data_req_o   = ex_mem_i.valid && (ex_mem_i.load || ex_mem_i.store);
    assign data_wr_o    = ex_mem_i.valid && ex_mem_i.store;
    assign data_addr_o  = ex_mem_i.result;
    assign data_wdata_o = ex_mem_i.store_data;

    assign mem_stall_o = data_req_o && !data_data_ok_i;  // no stall on a zero-wait answer

    assign wdata = ex_mem_i.load ? data_rdata_i : ex_mem_i.result;
    assign wreg  = ex_mem_i.valid && ex_mem_i.wreg;

    always_comb begin
        mem_wb_o.valid = ex_mem_i.valid;
        mem_wb_o.pc    = ex_mem_i.pc;
        mem_wb_o.wdata = wdata;
        mem_wb_o.dest  = ex_mem_i.dest;
        mem_wb_o.wreg  = wreg;
    end

    // forwarded to decode; only used while not stalled
    assign mem_wd_o    = ex_mem_i.dest;
    assign mem_wreg_o  = wreg;
    assign mem_wdata_o = wdata;

endmodule

`default_nettype wire

// File: src/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core (
    input  logic                            clk,
    input  logic                            rst,
    output logic [mips_isa_pkg::XLEN-1:0]   inst_addr_o,
    input  logic [mips_isa_pkg::XLEN-1:0]   inst_rdata_i,
    output logic                            data_req_o,
    output logic                            data_wr_o,
    output logic [mips_isa_pkg::XLEN-1:0]   data_addr_o,
    output logic [mips_isa_pkg::XLEN-1:0]   data_wdata_o,
    input  logic [mips_isa_pkg::XLEN-1:0]   data_rdata_i,
    input  logic                            data_data_ok_i,
    output logic [mips_isa_pkg::XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]                      debug_wb_rf_wen_o,
    output logic [mips_isa_pkg::REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [mips_isa_pkg::XLEN-1:0]   debug_wb_rf_wdata_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    stage_en_t en;
    logic      bubble_id_ex;
    logic      bubble_mem_wb;
    logic      mem_stall;
    logic      load_use;

    logic [XLEN-1:0]   id_pc;
    logic [XLEN-1:0]   id_inst;
    logic              branch;
    logic [XLEN-1:0]   branch_target;
    logic [REG_AW-1:0] rs_addr;
    logic [REG_AW-1:0] rt_addr;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;

    logic [REG_AW-1:0] ex_wd;
    logic              ex_wreg;
    logic [XLEN-1:0]   ex_wdata;
    logic [REG_AW-1:0] mem_wd;
    logic              mem_wreg;
    logic [XLEN-1:0]   mem_wdata;

    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    // load in execute feeding the instruction in decode
    assign load_use = id_ex_q.valid && id_ex_q.load && id_ex_q.wreg &&
                      (id_ex_q.dest == rs_addr || id_ex_q.dest == rt_addr);

    always_comb begin
        en            = '1;
        bubble_id_ex  = 1'b0;
        bubble_mem_wb = 1'b0;
        if (mem_stall) begin
            en            = '0;
            bubble_mem_wb = 1'b1;
        end else if (load_use) begin
            en.pc        = 1'b0;
            en.if_id     = 1'b0;
            en.id_ex     = 1'b0;
            bubble_id_ex = 1'b1;
        end
    end

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .en_pc_i(en.pc), .en_if_id_i(en.if_id),
        .branch_i(branch && en.id_ex),  // redirect only when decode advances
        .branch_target_i(branch_target),
        .inst_addr_o(inst_addr_o), .inst_rdata_i(inst_rdata_i),
        .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decoder u_decoder (
        .pc_i(id_pc), .inst_i(id_inst),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
        .ex_wd_i(ex_wd), .ex_wreg_i(ex_wreg), .ex_wdata_i(ex_wdata),
        .mem_wd_i(mem_wd), .mem_wreg_i(mem_wreg), .mem_wdata_i(mem_wdata),
        .id_ex_o(id_ex_d), .branch_o(branch), .branch_target_o(branch_target)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst),
        .we_i(mem_wb_q.wreg), .waddr_i(mem_wb_q.dest), .wdata_i(mem_wb_q.wdata),
        .raddr1_i(rs_addr), .raddr2_i(rt_addr),
        .rdata1_o(rs_data), .rdata2_o(rt_data)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst(rst), .en_i(en.id_ex), .bubble_i(bubble_id_ex),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    alu_stage u_alu (
        .id_ex_i(id_ex_q), .ex_mem_o(ex_mem_d),
        .ex_wd_o(ex_wd), .ex_wreg_o(ex_wreg), .ex_wdata_o(ex_wdata)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst(rst), .en_i(en.ex_mem), .bubble_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    mem_access u_mem (
        .ex_mem_i(ex_mem_q),
        .data_req_o(data_req_o), .data_wr_o(data_wr_o),
        .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
        .data_rdata_i(data_rdata_i), .data_data_ok_i(data_data_ok_i),
        .mem_stall_o(mem_stall), .mem_wb_o(mem_wb_d),
        .mem_wd_o(mem_wd), .mem_wreg_o(mem_wreg), .mem_wdata_o(mem_wdata)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst(rst), .en_i(en.mem_wb), .bubble_i(bubble_mem_wb),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

    assign debug_wb_pc_o       = mem_wb_q.pc;
    assign debug_wb_rf_wen_o   = {4{mem_wb_q.wreg}};
    assign debug_wb_rf_wnum_o  = mem_wb_q.dest;
    assign debug_wb_rf_wdata_o = mem_wb_q.wdata;

    // a waiting request must not move, ex_mem is frozen by mem_stall
    data_req_stable: assert property (@(posedge clk) disable iff (rst)
        data_req_o && !data_data_ok_i |=>
            data_req_o && $stable(data_wr_o) && $stable(data_addr_o) && $stable(data_wdata_o));

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = mips_pipe_pkg::mem_wb_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk) begin
        if (rst || bubble_i) begin
            q_o <= '0;          // valid drops with the rest
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

    // hazard control either holds a stage or empties it, never both
    en_bubble_excl: assert property (@(posedge clk) disable iff (rst) !(en_i && bubble_i));

endmodule

`default_nettype wire

// File: verif/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int PROG_LEN   = 208;
    localparam int LOOP_IDX   = PROG_LEN - 2;   // beq $0,$0,-1 and its delay slot
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 64;
    localparam int WORK_REGS  = 8;              // results go to $1..$7, $0 now and then
    localparam logic [REG_AW-1:0] BASE_REG  = REG_AW'(8);
    localparam logic [XLEN-1:0]   DMEM_BASE = 32'h0000_1000;
    localparam logic [XLEN-1:0]   LOOP_PC   = RESET_PC + XLEN'(4 * LOOP_IDX);

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   inst_addr_o;
    logic [XLEN-1:0]   inst_rdata_i;
    logic              data_req_o;
    logic              data_wr_o;
    logic [XLEN-1:0]   data_addr_o;
    logic [XLEN-1:0]   data_wdata_o;
    logic [XLEN-1:0]   data_rdata_i;
    logic              data_data_ok_i;
    logic [XLEN-1:0]   debug_wb_pc_o;
    logic [3:0]        debug_wb_rf_wen_o;
    logic [REG_AW-1:0] debug_wb_rf_wnum_o;
    logic [XLEN-1:0]   debug_wb_rf_wdata_o;

    integer          seed;
    int              errors;
    int              wb_checked;
    int              st_checked;
    int              wait_left;
    logic            rst_q;
    logic            req_waiting;
    logic            held_wr;
    logic [XLEN-1:0] held_addr;
    logic [XLEN-1:0] held_wdata;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] ref_dmem [DMEM_WORDS];
    logic [XLEN-1:0] ref_regs [NUM_REGS];

    logic [XLEN-1:0]   exp_wb_pc [$];
    logic [REG_AW-1:0] exp_wb_num [$];
    logic [XLEN-1:0]   exp_wb_data [$];
    logic [XLEN-1:0]   exp_st_addr [$];
    logic [XLEN-1:0]   exp_st_data [$];

    mips_core u_dut (.*);

    // both memories read combinationally
    assign inst_rdata_i = imem[inst_addr_o[9:2]];
    assign data_rdata_i = dmem[data_addr_o[7:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [XLEN-1:0] r_inst(input logic [REG_AW-1:0] rs,
                                               input logic [REG_AW-1:0] rt,
                                               input logic [REG_AW-1:0] rd,
                                               input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_inst(input logic [5:0] op,
                                               input logic [REG_AW-1:0] rs,
                                               input logic [REG_AW-1:0] rt,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [REG_AW-1:0] pick_src(input logic use_prev,
                                                   input logic [REG_AW-1:0] prev);
        if (use_prev) return prev;
        return REG_AW'(rand_below(WORK_REGS + 1));  // base register may be read too
    endfunction

    function automatic logic [REG_AW-1:0] pick_dest();
        if (rand_below(16) == 0) return REG_ZERO;
        return REG_AW'(1 + rand_below(WORK_REGS - 1));
    endfunction

    function automatic logic [5:0] pick_funct();
        case (rand_below(6))
            0:       return FN_ADDU;
            1:       return FN_SUBU;
            2:       return FN_AND;
            3:       return FN_OR;
            4:       return FN_XOR;
            default: return FN_SLT;
        endcase
    endfunction

    task automatic gen_program();
        int                i;
        int                kind;
        int                off;
        logic [REG_AW-1:0] prev;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic              after_load;
        logic              after_branch;
        for (i = 0; i < IMEM_WORDS; i++) imem[i] = INST_NOP;
        imem[0] = i_inst(OP_ADDIU, REG_ZERO, BASE_REG, DMEM_BASE[15:0]);
        for (i = 1; i < WORK_REGS; i++) begin
            imem[i] = i_inst(OP_ADDIU, REG_ZERO, REG_AW'(i), 16'(rand_below(65536)));
        end
        prev         = REG_AW'(WORK_REGS - 1);
        after_load   = 1'b0;
        after_branch = 1'b0;
        for (i = WORK_REGS; i < LOOP_IDX; i++) begin
            kind = rand_below(11);
            if (after_load) kind = 0;       // consumer right behind the load
            if (kind >= 9 && (after_branch || i + 2 > LOOP_IDX)) kind = 4;
            rs = pick_src(after_load || rand_below(2) == 0, prev);
            rt = pick_src(rand_below(3) == 0, prev);
            after_load   = 1'b0;
            after_branch = 1'b0;
            case (kind)
                4, 5, 6: begin
                    rd = pick_dest();
                    imem[i] = i_inst(kind == 4 ? OP_ADDIU : kind == 5 ? OP_ORI : OP_LUI,
                                     rs, rd, 16'(rand_below(65536)));
                    prev = rd;
                end
                7: begin
                    rd = pick_dest();
                    imem[i] = i_inst(OP_LW, BASE_REG, rd, 16'(4 * rand_below(DMEM_WORDS)));
                    prev       = rd;
                    after_load = 1'b1;
                end
                8: imem[i] = i_inst(OP_SW, BASE_REG, rt, 16'(4 * rand_below(DMEM_WORDS)));
                9, 10: begin
                    off = 1 + rand_below(3);
                    if (i + 1 + off > LOOP_IDX) off = LOOP_IDX - i - 1;
                    if (rand_below(3) == 0) rt = rs;
                    imem[i] = i_inst(kind == 9 ? OP_BEQ : OP_BNE, rs, rt, 16'(off));
                    after_branch = 1'b1;
                end
                default: begin
                    rd = pick_dest();
                    imem[i] = r_inst(rs, rt, rd, pick_funct());
                    prev = rd;
                end
            endcase
        end
        imem[LOOP_IDX] = i_inst(OP_BEQ, REG_ZERO, REG_ZERO, 16'hffff);
    endtask

    task automatic write_reg(input logic [XLEN-1:0] pc, input logic [REG_AW-1:0] num,
                             input logic [XLEN-1:0] val);
        if (num != REG_ZERO) begin
            ref_regs[num] = val;
            exp_wb_pc.push_back(pc);
            exp_wb_num.push_back(num);
            exp_wb_data.push_back(val);
        end
    endtask

    // ISA model with one delay slot, runs the program up to the final loop
    task automatic run_model();
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   npc;
        logic [XLEN-1:0]   nnpc;
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   sext;
        logic [XLEN-1:0]   addr;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        int                steps;
        for (int r = 0; r < NUM_REGS; r++) ref_regs[r] = '0;
        for (int w = 0; w < DMEM_WORDS; w++) ref_dmem[w] = fill_word(DMEM_BASE + XLEN'(4 * w));
        pc    = RESET_PC;
        npc   = RESET_PC + 32'd4;
        steps = 0;
        while (pc != LOOP_PC && steps < 4 * PROG_LEN) begin
            inst = imem[pc[9:2]];
            rt   = inst[20:16];
            rd   = inst[15:11];
            a    = ref_regs[inst[25:21]];
            b    = ref_regs[rt];
            sext = {{16{inst[15]}}, inst[15:0]};
            addr = a + sext;
            nnpc = npc + 32'd4;
            case (inst[31:26])
                OP_SPECIAL: begin
                    case (inst[5:0])
                        FN_ADDU: write_reg(pc, rd, a + b);
                        FN_SUBU: write_reg(pc, rd, a - b);
                        FN_AND:  write_reg(pc, rd, a & b);
                        FN_OR:   write_reg(pc, rd, a | b);
                        FN_XOR:  write_reg(pc, rd, a ^ b);
                        FN_SLT:  write_reg(pc, rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                OP_ADDIU: write_reg(pc, rt, addr);
                OP_ORI:   write_reg(pc, rt, a | {16'h0000, inst[15:0]});
                OP_LUI:   write_reg(pc, rt, {inst[15:0], 16'h0000});
                OP_LW:    write_reg(pc, rt, ref_dmem[addr[7:2]]);
                OP_SW: begin
                    ref_dmem[addr[7:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                OP_BEQ: if (a == b) nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                OP_BNE: if (a != b) nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                default: ;
            endcase
            pc  = npc;
            npc = nnpc;
            steps++;
        end
        if (pc != LOOP_PC) report_error("reference model never reached the final loop");
    endtask

    // data memory with 0 to 3 wait cycles per request
    always @(posedge clk) begin : dmem_model
        int w;
        if (!rst) begin
            if (req_waiting) begin
                assert (data_req_o && data_wr_o == held_wr && data_addr_o == held_addr &&
                        data_wdata_o == held_wdata)
                else report_error($sformatf("request moved while waiting, addr %h", held_addr));
            end
            if (data_req_o && data_data_ok_i) begin
                assert (data_addr_o[XLEN-1:8] == DMEM_BASE[XLEN-1:8] && data_addr_o[1:0] == 2'b00)
                else report_error($sformatf("data address %h outside memory", data_addr_o));
                if (data_wr_o) begin
                    dmem[data_addr_o[7:2]] <= data_wdata_o;
                    assert (exp_st_addr.size() != 0) else report_error("store with none expected");
                    if (exp_st_addr.size() != 0) begin
                        assert (data_addr_o == exp_st_addr[0] && data_wdata_o == exp_st_data[0])
                        else report_error($sformatf("store %h <- %h, expected %h <- %h",
                            data_addr_o, data_wdata_o, exp_st_addr[0], exp_st_data[0]));
                        void'(exp_st_addr.pop_front());
                        void'(exp_st_data.pop_front());
                        st_checked++;
                    end
                end
                w = rand_below(4);
                wait_left      <= w;
                data_data_ok_i <= (w == 0);
            end else if (data_req_o) begin
                wait_left      <= wait_left - 1;
                data_data_ok_i <= (wait_left == 1);
            end
            req_waiting <= data_req_o && !data_data_ok_i;
            held_wr     <= data_wr_o;
            held_addr   <= data_addr_o;
            held_wdata  <= data_wdata_o;
        end
    end

    always @(posedge clk) begin : wb_check
        if (rst_q) begin
            assert (inst_addr_o == RESET_PC)
            else report_error($sformatf("fetch address %h after reset", inst_addr_o));
            assert (!data_req_o && debug_wb_rf_wen_o == 4'h0)
            else report_error("data request or write-back active in reset");
        end
        if (!rst && debug_wb_rf_wen_o != 4'h0) begin
            assert (debug_wb_rf_wen_o == 4'hf) else report_error("partial write enable");
            assert (debug_wb_rf_wnum_o != REG_ZERO) else report_error("write to r0 retired");
            assert (exp_wb_pc.size() != 0) else report_error("register write with none expected");
            if (exp_wb_pc.size() != 0) begin
                assert (debug_wb_pc_o == exp_wb_pc[0] && debug_wb_rf_wnum_o == exp_wb_num[0] &&
                        debug_wb_rf_wdata_o == exp_wb_data[0])
                else report_error($sformatf("pc %h r%0d = %h, expected pc %h r%0d = %h",
                    debug_wb_pc_o, debug_wb_rf_wnum_o, debug_wb_rf_wdata_o,
                    exp_wb_pc[0], exp_wb_num[0], exp_wb_data[0]));
                void'(exp_wb_pc.pop_front());
                void'(exp_wb_num.pop_front());
                void'(exp_wb_data.pop_front());
                wb_checked++;
            end
        end
        rst_q <= rst;
    end

    initial begin : watchdog
        #(20 * PROG_LEN * CLK_PERIOD);
        $display("Timeout: program did not finish within %0d cycles", 20 * PROG_LEN);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        seed           = 32'hfa7c_4c53;
        errors         = 0;
        wb_checked     = 0;
        st_checked     = 0;
        rst            = 1'b1;
        rst_q          = 1'b0;
        req_waiting    = 1'b0;
        held_wr        = 1'b0;
        held_addr      = '0;
        held_wdata     = '0;
        data_data_ok_i = 1'b0;
        for (int w = 0; w < DMEM_WORDS; w++) dmem[w] = fill_word(DMEM_BASE + XLEN'(4 * w));
        gen_program();
        run_model();
        wait_left      = rand_below(4);
        data_data_ok_i = (wait_left == 0);

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // done once the core spins in the final loop and everything retired
        while (inst_addr_o != LOOP_PC) @(negedge clk);
        while (exp_wb_pc.size() != 0 || exp_st_addr.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);
        assert (inst_addr_o == LOOP_PC || inst_addr_o == LOOP_PC + 32'd4)
        else report_error($sformatf("core left the final loop, fetching %h", inst_addr_o));

        $display("Result: %0d errors, %0d register writes and %0d stores checked",
                 errors, wb_checked, st_checked);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
